// ==== design/rv_alu.sv ====
`include "rv_cfg.svh"

module rv_alu import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  alu_op_t             op,
  input  logic [2:0]          funct3,
  output logic [`RV_XLEN-1:0] result,
  output logic                branch_taken
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // beq and bne look at the difference, the rest at the slt bit
  // funct3[0] inverts the sense
  always_comb begin
    if (funct3[2]) begin
      branch_taken = result[0] ^ funct3[0];
    end else begin
      branch_taken = (result == '0) ^ funct3[0];
    end
  end

endmodule

// ==== design/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// one quotient bit per divider iteration
`define RV_DIV_STEPS 32

`endif

// ==== design/rv_control.sv ====
module rv_control import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  insn_class_t insn_class,
  input  logic        branch_taken,
  input  logic        div_done,
  output logic        pc_we,
  output logic        pc_sel_target,
  output logic        rf_we,
  output logic        dmem_we,
  output logic        div_start,
  output logic        halt
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next    = state;
    pc_we         = 1'b0;
    pc_sel_target = 1'b0;
    rf_we         = 1'b0;
    dmem_we       = 1'b0;
    div_start     = 1'b0;
    case (state)
      st_fetch: state_next = st_execute;
      st_execute: begin
        state_next = st_fetch;
        pc_we      = 1'b1;
        case (insn_class)
          cls_alu: rf_we = 1'b1;
          cls_jal, cls_jalr: begin
            rf_we         = 1'b1;
            pc_sel_target = 1'b1;
          end
          cls_branch: pc_sel_target = branch_taken;
          cls_store:  dmem_we = 1'b1;
          // multi-cycle classes finish later
          cls_load: begin
            pc_we      = 1'b0;
            state_next = st_load_wait;
          end
          cls_divide: begin
            pc_we      = 1'b0;
            div_start  = 1'b1;
            state_next = st_div_wait;
          end
          cls_halt: begin
            pc_we      = 1'b0;
            state_next = st_halted;
          end
          default: pc_we = 1'b1;
        endcase
      end
      st_load_wait: begin
        rf_we      = 1'b1;
        pc_we      = 1'b1;
        state_next = st_fetch;
      end
      st_div_wait: begin
        if (div_done) begin
          rf_we      = 1'b1;
          pc_we      = 1'b1;
          state_next = st_fetch;
        end
      end
      st_halted: state_next = st_halted;
      default:   state_next = st_fetch;
    endcase
  end

  assign halt = (state == st_halted);

  assert property (@(posedge clk) disable iff (rst) !(dmem_we && rf_we));

endmodule

// ==== design/rv_core.sv ====
`include "rv_cfg.svh"

module rv_core import rv_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_rdata,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic                dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                halt
);

  logic [`RV_XLEN-1:0]      pc;
  logic [`RV_XLEN-1:0]      pc_plus4;
  logic [`RV_XLEN-1:0]      target_sum;
  logic [`RV_XLEN-1:0]      pc_target;
  insn_class_t              insn_class;
  alu_op_t                  alu_op;
  wb_sel_t                  wb_sel;
  logic                     use_imm;
  logic                     a_is_pc;
  logic [`RV_XLEN-1:0]      imm;
  logic [`RV_REG_IDX_W-1:0] rs1_idx;
  logic [`RV_REG_IDX_W-1:0] rs2_idx;
  logic [`RV_REG_IDX_W-1:0] rd_idx;
  logic [`RV_XLEN-1:0]      rs1_data;
  logic [`RV_XLEN-1:0]      rs2_data;
  logic [`RV_XLEN-1:0]      rd_data;
  logic [`RV_XLEN-1:0]      alu_result;
  logic [`RV_XLEN-1:0]      quotient;
  logic [`RV_XLEN-1:0]      remainder;
  logic                     branch_taken;
  logic                     div_done;
  logic                     pc_we;
  logic                     pc_sel_target;
  logic                     rf_we;
  logic                     div_start;

  // pc only moves in the last cycle of an instruction
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (pc_we) begin
      pc <= pc_sel_target ? pc_target : pc_plus4;
    end
  end

  assign imem_addr = pc;
  assign pc_plus4  = pc + `RV_XLEN'(4);

  // jalr is register relative, bit 0 dropped
  assign target_sum = ((insn_class == cls_jalr) ? rs1_data : pc) + imm;
  assign pc_target  = {target_sum[`RV_XLEN-1:1], 1'b0};

  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;

  always_comb begin
    case (wb_sel)
      wb_pc_plus4:  rd_data = pc_plus4;
      wb_load:      rd_data = dmem_rdata;
      wb_quotient:  rd_data = quotient;
      wb_remainder: rd_data = remainder;
      default:      rd_data = alu_result;
    endcase
  end

  rv_regfile i_regfile (
    .clk(clk), .rst(rst), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .rd_idx(rd_idx), .rd_data(rd_data), .we(rf_we)
  );

  rv_decode i_decode (
    .insn(imem_rdata), .insn_class(insn_class), .alu_op(alu_op), .use_imm(use_imm),
    .a_is_pc(a_is_pc), .imm(imm), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .rd_idx(rd_idx), .wb_sel(wb_sel)
  );

  rv_alu i_alu (
    .a(a_is_pc ? pc : rs1_data), .b(use_imm ? imm : rs2_data), .op(alu_op),
    .funct3(imem_rdata[14:12]), .result(alu_result), .branch_taken(branch_taken)
  );

  rv_divider i_divider (
    .clk(clk), .rst(rst), .start(div_start), .dividend(rs1_data), .divisor(rs2_data),
    .quotient(quotient), .remainder(remainder), .done(div_done)
  );

  rv_control i_control (
    .clk(clk), .rst(rst), .insn_class(insn_class), .branch_taken(branch_taken),
    .div_done(div_done), .pc_we(pc_we), .pc_sel_target(pc_sel_target), .rf_we(rf_we),
    .dmem_we(dmem_we), .div_start(div_start), .halt(halt)
  );

  assert property (@(posedge clk) disable iff (rst) dmem_we |-> dmem_addr[1:0] == 2'b00);

endmodule

// ==== design/rv_decode.sv ====
`include "rv_cfg.svh"

module rv_decode import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0]      insn,
  output insn_class_t              insn_class,
  output alu_op_t                  alu_op,
  output logic                     use_imm,
  output logic                     a_is_pc,
  output logic [`RV_XLEN-1:0]      imm,
  output logic [`RV_REG_IDX_W-1:0] rs1_idx,
  output logic [`RV_REG_IDX_W-1:0] rs2_idx,
  output logic [`RV_REG_IDX_W-1:0] rd_idx,
  output wb_sel_t                  wb_sel
);

  opcode_t             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode  = opcode_t'(insn[6:0]);
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign rd_idx  = insn[11:7];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];

  // sign-extended immediates, one per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    insn_class = cls_nop;
    alu_op     = alu_add;
    use_imm    = 1'b0;
    a_is_pc    = 1'b0;
    imm        = imm_i;
    wb_sel     = wb_alu;
    case (opcode)
      op_lui: begin
        insn_class = cls_alu;
        alu_op     = alu_pass_b;
        use_imm    = 1'b1;
        imm        = imm_u;
      end
      op_auipc: begin
        insn_class = cls_alu;
        use_imm    = 1'b1;
        a_is_pc    = 1'b1;
        imm        = imm_u;
      end
      op_jal: begin
        insn_class = cls_jal;
        imm        = imm_j;
        wb_sel     = wb_pc_plus4;
      end
      op_jalr: begin
        insn_class = (funct3 == 3'b000) ? cls_jalr : cls_nop;
        wb_sel     = wb_pc_plus4;
      end
      op_branch: begin
        imm        = imm_b;
        insn_class = (funct3[2:1] == 2'b01) ? cls_nop : cls_branch;
        case (funct3[2:1])
          2'b00:   alu_op = alu_sub;
          2'b10:   alu_op = alu_slt;
          default: alu_op = alu_sltu;
        endcase
      end
      op_load: begin
        insn_class = (funct3 == 3'b010) ? cls_load : cls_nop;
        use_imm    = 1'b1;
        wb_sel     = wb_load;
      end
      op_store: begin
        insn_class = (funct3 == 3'b010) ? cls_store : cls_nop;
        use_imm    = 1'b1;
        imm        = imm_s;
      end
      op_imm, op_reg: begin
        use_imm    = (opcode == op_imm);
        insn_class = cls_alu;
        case (funct3)
          3'b000:  alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // funct7 legality, immediate forms only carry it for shifts
        if (opcode == op_reg && funct7 == 7'b000_0001) begin
          insn_class = (funct3 == 3'b101 || funct3 == 3'b111) ? cls_divide : cls_nop;
          wb_sel     = funct3[1] ? wb_remainder : wb_quotient;
        end else if (opcode == op_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
          if (funct7 != 7'b000_0000 &&
              !(funct7 == 7'b010_0000 && (funct3 == 3'b101 ||
                (funct3 == 3'b000 && opcode == op_reg)))) begin
            insn_class = cls_nop;
          end
        end
      end
      op_system: begin
        insn_class = (insn[31:7] == '0) ? cls_halt : cls_nop;
      end
      default: insn_class = cls_nop;
    endcase
  end

endmodule

// ==== design/rv_divider.sv ====
`include "rv_cfg.svh"

module rv_divider (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [`RV_XLEN-1:0] dividend,
  input  logic [`RV_XLEN-1:0] divisor,
  output logic [`RV_XLEN-1:0] quotient,
  output logic [`RV_XLEN-1:0] remainder,
  output logic                done
);

  localparam int count_w = $clog2(`RV_DIV_STEPS + 1);

  logic [`RV_XLEN-1:0]   divisor_q;
  logic [count_w-1:0]    steps_left;
  logic                  busy;
  logic [2*`RV_XLEN-1:0] first_step;
  logic [2*`RV_XLEN-1:0] next_step;

  // one restoring step, returns {remainder, quotient}
  // quotient register doubles as the dividend shifter
  function automatic logic [2*`RV_XLEN-1:0] div_step(
    input logic [`RV_XLEN-1:0] rem,
    input logic [`RV_XLEN-1:0] quo,
    input logic [`RV_XLEN-1:0] dsr
  );
    logic [`RV_XLEN:0] partial;
    logic [`RV_XLEN:0] diff;
    partial = {rem, quo[`RV_XLEN-1]};
    diff    = partial - {1'b0, dsr};
    if (diff[`RV_XLEN]) begin
      div_step = {partial[`RV_XLEN-1:0], quo[`RV_XLEN-2:0], 1'b0};
    end else begin
      div_step = {diff[`RV_XLEN-1:0], quo[`RV_XLEN-2:0], 1'b1};
    end
  endfunction

  // the start edge already does the first step
  assign first_step = div_step('0, dividend, divisor);
  assign next_step  = div_step(remainder, quotient, divisor_q);
  assign done       = busy && (steps_left == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy       <= 1'b0;
      steps_left <= '0;
    end else if (start) begin
      busy       <= 1'b1;
      steps_left <= count_w'(`RV_DIV_STEPS - 1);
    end else if (busy) begin
      if (steps_left == '0) begin
        busy <= 1'b0;
      end else begin
        steps_left <= steps_left - 1'b1;
      end
    end
  end

  // results hold until the next start
  always_ff @(posedge clk) begin
    if (start) begin
      divisor_q               <= divisor;
      {remainder, quotient}   <= first_step;
    end else if (busy && steps_left != '0) begin
      {remainder, quotient}   <= next_step;
    end
  end

  assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_branch = 7'b110_0011,
    op_jalr   = 7'b110_0111,
    op_jal    = 7'b110_1111,
    op_imm    = 7'b001_0011,
    op_reg    = 7'b011_0011,
    op_system = 7'b111_0011,
    op_auipc  = 7'b001_0111,
    op_lui    = 7'b011_0111
  } opcode_t;

  // what the FSM has to sequence
  typedef enum logic [3:0] {
    cls_alu, cls_load, cls_store, cls_branch, cls_jal,
    cls_jalr, cls_divide, cls_halt, cls_nop
  } insn_class_t;

  // branches reuse sub, slt and sltu
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    wb_alu, wb_pc_plus4, wb_load, wb_quotient, wb_remainder
  } wb_sel_t;

  typedef enum logic [2:0] {
    st_fetch, st_execute, st_load_wait, st_div_wait, st_halted
  } ctrl_state_t;

endpackage

// ==== design/rv_regfile.sv ====
`include "rv_cfg.svh"

module rv_regfile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`RV_REG_IDX_W-1:0] rs1_idx,
  input  logic [`RV_REG_IDX_W-1:0] rs2_idx,
  output logic [`RV_XLEN-1:0]      rs1_data,
  output logic [`RV_XLEN-1:0]      rs2_data,
  input  logic [`RV_REG_IDX_W-1:0] rd_idx,
  input  logic [`RV_XLEN-1:0]      rd_data,
  input  logic                     we
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // slot 0 is cleared on reset and never written, so x0 reads zero
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    (rs1_idx != '0 || rs1_data == '0) && (rs2_idx != '0 || rs2_data == '0));

endmodule

// ==== run.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rv_core_tb \
  -o rv_core_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv_core_tb > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; } \
  || echo "simulation passed"

// ==== sim/program_input.txt ====
# p word: program word, from address 0 upward
# d addr word: initial data word
# s addr data: next expected store, in order
p 20000513  # addi x10, x0, 0x200
p FF900093  # addi x1, x0, -7
p 00C00113  # addi x2, x0, 12
p 123451B7  # lui x3, 0x12345
p 00001217  # auipc x4, 1
p 00352023  # sw x3, 0(x10)
p 00452223  # sw x4, 4(x10)
p 06408293  # addi x5, x1, 100
p 0010A313  # slti x6, x1, 1
p 0050B393  # sltiu x7, x1, 5
p 0F00C413  # xori x8, x1, 0xf0
p 70116493  # ori x9, x2, 0x701
p FF00F593  # andi x11, x1, -16
p 01C11613  # slli x12, x2, 28
p 0040D693  # srli x13, x1, 4
p 4010D713  # srai x14, x1, 1
p 00552423  # sw x5, 8(x10)
p 00652623  # sw x6, 12(x10)
p 00752823  # sw x7, 16(x10)
p 00852A23  # sw x8, 20(x10)
p 00952C23  # sw x9, 24(x10)
p 00B52E23  # sw x11, 28(x10)
p 02C52023  # sw x12, 32(x10)
p 02D52223  # sw x13, 36(x10)
p 02E52423  # sw x14, 40(x10)
p 002082B3  # add x5, x1, x2
p 40110333  # sub x6, x2, x1
p 002093B3  # sll x7, x1, x2
p 0020A433  # slt x8, x1, x2
p 0020B4B3  # sltu x9, x1, x2
p 0020C5B3  # xor x11, x1, x2
p 0020D633  # srl x12, x1, x2
p 4020D6B3  # sra x13, x1, x2
p 0020E733  # or x14, x1, x2
p 0020F7B3  # and x15, x1, x2
p 02552623  # sw x5, 44(x10)
p 02652823  # sw x6, 48(x10)
p 02752A23  # sw x7, 52(x10)
p 02852C23  # sw x8, 56(x10)
p 02952E23  # sw x9, 60(x10)
p 04B52023  # sw x11, 64(x10)
p 04C52223  # sw x12, 68(x10)
p 04D52423  # sw x13, 72(x10)
p 04E52623  # sw x14, 76(x10)
p 04F52823  # sw x15, 80(x10)
p 10052803  # lw x16, 0x100(x10)
p 00052883  # lw x17, 0(x10)
p 05052A23  # sw x16, 84(x10)
p 05152C23  # sw x17, 88(x10)
p 05852903  # lw x18, 88(x10)
p 05252E23  # sw x18, 92(x10)
p 0220D9B3  # divu x19, x1, x2
p 0220FA33  # remu x20, x1, x2
p 02015AB3  # divu x21, x2, x0
p 02017B33  # remu x22, x2, x0
p 07352023  # sw x19, 96(x10)
p 07452223  # sw x20, 100(x10)
p 07552423  # sw x21, 104(x10)
p 07652623  # sw x22, 108(x10)
p 00210463  # beq x2, x2, +8 taken
p 040B8B93  # addi x23, x23, 64 skipped
p 00208463  # beq x1, x2, +8 not taken
p 001B8B93  # addi x23, x23, 1
p 00209463  # bne x1, x2, +8 taken
p 080B8B93  # addi x23, x23, 128 skipped
p 00211463  # bne x2, x2, +8 not taken
p 002B8B93  # addi x23, x23, 2
p 0020C463  # blt x1, x2, +8 taken
p 100B8B93  # addi x23, x23, 256 skipped
p 00114463  # blt x2, x1, +8 not taken
p 004B8B93  # addi x23, x23, 4
p 00115463  # bge x2, x1, +8 taken
p 200B8B93  # addi x23, x23, 512 skipped
p 0020D463  # bge x1, x2, +8 not taken
p 008B8B93  # addi x23, x23, 8
p 00116463  # bltu x2, x1, +8 taken
p 400B8B93  # addi x23, x23, 1024 skipped
p 0020E463  # bltu x1, x2, +8 not taken
p 010B8B93  # addi x23, x23, 16
p 0020F463  # bgeu x1, x2, +8 taken
p 7FFB8B93  # addi x23, x23, 2047 skipped
p 00117463  # bgeu x2, x1, +8 not taken
p 020B8B93  # addi x23, x23, 32
p 07752823  # sw x23, 112(x10)
p 00800C6F  # 0x150 jal x24, +8
p 00052023  # sw x0, 0(x10) skipped
p 07852A23  # sw x24, 116(x10)
p 00000C97  # 0x15c auipc x25, 0
p 00DC8D67  # 0x160 jalr x26, 13(x25)
p 00052223  # sw x0, 4(x10) skipped
p 07A52C23  # 0x168 sw x26, 120(x10)
p 00000073  # ecall
p 00052423  # sw x0, 8(x10) never reached
d 300 CAFEF00D
s 200 12345000
s 204 00001010
s 208 0000005D
s 20C 00000001
s 210 00000000
s 214 FFFFFF09
s 218 0000070D
s 21C FFFFFFF0
s 220 C0000000
s 224 0FFFFFFF
s 228 FFFFFFFC
s 22C 00000005
s 230 00000013
s 234 FFFF9000
s 238 00000001
s 23C 00000000
s 240 FFFFFFF5
s 244 000FFFFF
s 248 FFFFFFFF
s 24C FFFFFFFD
s 250 00000008
s 254 CAFEF00D
s 258 12345000
s 25C 12345000
s 260 15555554
s 264 00000009
s 268 FFFFFFFF
s 26C 0000000C
s 270 0000003F
s 274 00000154
s 278 00000164

// ==== sim/rv_core_tb.sv ====
`include "rv_cfg.svh"

module rv_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    mem_words  = 256;
  localparam int    max_stores = 64;
  localparam string input_path = "sim/program_input.txt";
  localparam logic [`RV_XLEN-1:0] ecall_word = 32'h0000_0073;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic                dmem_we;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                halt;

  // one array behind both ports
  logic [`RV_XLEN-1:0] mem [mem_words];
  logic [`RV_XLEN-1:0] exp_addr [max_stores];
  logic [`RV_XLEN-1:0] exp_data [max_stores];
  int                  n_prog = 0;
  int                  n_exp = 0;
  bit                  loaded = 1'b0;
  logic [`RV_XLEN-1:0] ecall_addr = '0;
  bit                  ecall_found = 1'b0;

  int                  error_count = 0;
  int                  store_idx = 0;
  bit                  halt_seen = 1'b0;
  bit                  reset_checked = 1'b0;

  tb_clock i_clock (
    .clk(clk)
  );

  rv_core i_rv_core (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata), .halt(halt)
  );

  task automatic check_reset_outputs();
    if (dmem_we !== 1'b0) begin
      $display("[ERROR] dmem_we: expected %h, got %h", 1'b0, dmem_we);
      error_count++;
    end
    if (halt !== 1'b0) begin
      $display("[ERROR] halt: expected %h, got %h", 1'b0, halt);
      error_count++;
    end
    if (imem_addr !== `RV_RESET_PC) begin
      $display("[ERROR] imem_addr: expected %h, got %h", `RV_RESET_PC, imem_addr);
      error_count++;
    end
  endtask

  // compare one write against the next entry of the store list
  task automatic check_store();
    if (store_idx >= n_exp) begin
      $display("unexpected store of %h to address %h", dmem_wdata, dmem_addr);
      error_count++;
    end else begin
      if (dmem_addr !== exp_addr[store_idx]) begin
        $display("[ERROR] dmem_addr: store %0d expected %h, got %h",
                 store_idx, exp_addr[store_idx], dmem_addr);
        error_count++;
      end
      if (dmem_wdata !== exp_data[store_idx]) begin
        $display("[ERROR] dmem_wdata: store %0d expected %h, got %h",
                 store_idx, exp_data[store_idx], dmem_wdata);
        error_count++;
      end
      store_idx++;
    end
  endtask

  // file loader, then the synchronous memory itself
  initial begin
    int                  fd;
    int                  n;
    string               line;
    logic [`RV_XLEN-1:0] f1;
    logic [`RV_XLEN-1:0] f2;
    imem_rdata <= '0;
    dmem_rdata <= '0;
    void'($urandom(32'hbd17));
    for (int i = 0; i < mem_words; i++) begin
      mem[i] <= $urandom();
    end
    fd = $fopen(input_path, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", input_path);
      $display("*** FAILED ***");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 2) begin
          f1 = '0;
          f2 = '0;
          n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f1, f2);
          case (line[0])
            "p": begin
              // the core parks on the first ecall
              if (f1 == ecall_word && !ecall_found) begin
                ecall_addr  = `RV_XLEN'(n_prog * 4);
                ecall_found = 1'b1;
              end
              mem[n_prog[7:0]] <= f1;
              n_prog++;
            end
            "d": mem[f1[9:2]] <= f2;
            "s": begin
              exp_addr[n_exp] = f1;
              exp_data[n_exp] = f2;
              n_exp++;
            end
            default: ;
          endcase
        end
      end
      $fclose(fd);
      loaded = 1'b1;
      // read data is the old word, writes land on the same edge
      forever begin
        @(posedge clk);
        imem_rdata <= mem[imem_addr[9:2]];
        dmem_rdata <= mem[dmem_addr[9:2]];
        if (dmem_we) begin
          mem[dmem_addr[9:2]] <= dmem_wdata;
        end
      end
    end
  end

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    if (rst || !reset_checked) begin
      check_reset_outputs();
      reset_checked = !rst;
    end
    if (!rst) begin
      if (dmem_we) begin
        if (halt_seen) begin
          $display("store to address %h after the core halted", dmem_addr);
          error_count++;
        end
        check_store();
      end
      if (halt_seen && !halt) begin
        $display("halt dropped after ecall");
        error_count++;
      end
      // pc must stay on the ecall once halted
      if (halt && imem_addr !== ecall_addr) begin
        $display("[ERROR] imem_addr: expected %h after halt, got %h",
                 ecall_addr, imem_addr);
        error_count++;
      end
      if (halt && !halt_seen) begin
        halt_seen = 1'b1;
        if (store_idx != n_exp) begin
          $display("halt reached after %0d of %0d expected stores", store_idx, n_exp);
          error_count++;
        end
      end
    end
  end

  // no instruction needs more than 40 cycles
  initial begin
    int limit;
    wait (loaded);
    limit = n_prog * 40 + 100;
    repeat (limit) @(posedge clk);
    $display("timeout: core did not reach ecall within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (halt === 1'b1);
    // watch a few more cycles for late stores or a dropped halt
    repeat (10) @(negedge clk);
    @(posedge clk);
    $display("errors: %0d, stores checked: %0d of %0d", error_count, store_idx, n_exp);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

// ==== src.f ====
+incdir+design
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_divider.sv
design/rv_control.sv
design/rv_core.sv
sim/tb_clock.sv
sim/rv_core_tb.sv
